//--- verification/wfg_trace.txt
# T name div cpol lsbfirst dff sspol subcycle_div sync_count start inc en frames (hex, frames dec)
# F expected frame word in hex, cut to 8*(dff+1) bits
T msb8_cpol0 1 0 0 0 0 9 7 123456f0 00000007 1 4
F f0
F f7
F fe
F 05
T lsb32_div0 0 0 1 3 0 9 9 a5c30f81 01020304 1 3
F a5c30f81
F a6c51285
F a7c71589
T cpol1_sspol1_16 2 1 0 1 1 f 9 0000fffe 00000001 1 4
F fffe
F ffff
F 0000
F 0001
T wrap24 1 0 0 2 0 b b f0123456 0afff111 1 4
F 123456
F 122567
F 121678
F 120789
T disabled 1 0 0 0 0 3 3 00000000 00000001 0 0

//--- all.f
src/wfg_pkg.sv
src/wfg_core.sv
src/wfg_stim_ramp.sv
src/wfg_drive_spi.sv
src/wfg_top.sv
verification/wfg_tb.sv

//--- Bender.yml
package:
  name: wfg

sources:
  - src/wfg_pkg.sv
  - src/wfg_core.sv
  - src/wfg_stim_ramp.sv
  - src/wfg_drive_spi.sv
  - src/wfg_top.sv
  - target: test
    files:
      - verification/wfg_tb.sv

//--- verification/wfg_tb.sv
//**************************************************************************
// Testbench for wfg_top. Replays the trace file and decodes the SPI frames.
//**************************************************************************
`default_nettype none

module wfg_tb import wfg_pkg::*; ();

    localparam int MAX_TESTS = 8;

    logic      clk;
    logic      rst_n;
    logic      en;
    logic      ramp_load;
    core_cfg_t core_cfg;
    ramp_cfg_t ramp_cfg;
    spi_cfg_t  spi_cfg;
    logic      spi_sclk;
    logic      spi_cs_n;
    logic      spi_sdo;

    string       t_name [MAX_TESTS];
    spi_cfg_t    t_spi [MAX_TESTS];
    core_cfg_t   t_core [MAX_TESTS];
    ramp_cfg_t   t_ramp [MAX_TESTS];
    logic        t_en [MAX_TESTS];
    int          t_frames [MAX_TESTS];
    logic [31:0] exp_q [$];          // Expected words of all tests in order
    int          num_tests;
    int          budget;             // Watchdog limit in clock cycles
    string       cur_name;
    int          errors;
    int          checks;
    int          failed_tests;

    logic        mon_on;
    logic        sclk_q;
    logic        cs_act_q;
    logic [31:0] rx_word;
    int          rx_bits;
    logic [31:0] rx_q [$];           // Decoded words
    int          bits_q [$];         // Leading edges seen per frame

    wfg_top #(
        .AXIS_DATA_WIDTH (32)
    ) dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .en_i        (en),
        .core_cfg_i  (core_cfg),
        .ramp_cfg_i  (ramp_cfg),
        .ramp_load_i (ramp_load),
        .spi_cfg_i   (spi_cfg),
        .spi_sclk_o  (spi_sclk),
        .spi_cs_no   (spi_cs_n),
        .spi_sdo_o   (spi_sdo)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    task automatic step_clock();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("Error: test %s, %s, expected %h, actual %h",
                     cur_name, what, expected, actual);
        end
    endtask

    // Samples the pins at the falling clock edge, away from their updates
    always @(negedge clk) begin : frame_monitor
        logic cs_act;
        logic lead;
        int   nbits;
        cs_act = (spi_cs_n == spi_cfg.sspol);
        lead   = spi_cfg.cpol ? (sclk_q && !spi_sclk) : (!sclk_q && spi_sclk);
        nbits  = 8 * (int'(spi_cfg.dff) + 1);
        if (mon_on) begin
            if (cs_act && !cs_act_q) begin
                rx_word = '0;
                rx_bits = 0;
            end
            if (cs_act && lead) begin
                if (rx_bits < nbits) begin
                    if (spi_cfg.lsbfirst) begin
                        rx_word[rx_bits] = spi_sdo;
                    end else begin
                        rx_word[nbits - 1 - rx_bits] = spi_sdo;
                    end
                end
                rx_bits++;
            end
            if (!cs_act && cs_act_q) begin
                rx_q.push_back(rx_word);
                bits_q.push_back(rx_bits);
            end
        end
        sclk_q   = spi_sclk;
        cs_act_q = cs_act;
    end

    task automatic read_trace(output bit ok);
        int          fd;
        int          n;
        int          limit;
        int          total_frames;
        string       line;
        string       tag;
        string       name;
        int          div, cpol, lsb, dff, sspol, sdiv, scnt, en_v, frames;
        logic [31:0] start;
        logic [31:0] inc;
        logic [31:0] word;
        ok           = 1'b1;
        num_tests    = 0;
        limit        = 20;
        total_frames = 0;
        fd = $fopen("verification/wfg_trace.txt", "r");
        if (fd == 0) begin
            ok     = 1'b0;
            budget = limit;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            tag = "";
            void'($sscanf(line, "%s", tag));
            if (tag == "T") begin
                n = $sscanf(line, "T %s %h %h %h %h %h %h %h %h %h %h %d", name, div, cpol,
                            lsb, dff, sspol, sdiv, scnt, start, inc, en_v, frames);
                if (n != 12 || num_tests == MAX_TESTS) begin
                    ok = 1'b0;
                end else begin
                    t_name[num_tests]   = name;
                    t_spi[num_tests]    = {div[7:0], cpol[0], lsb[0], dff[1:0], sspol[0]};
                    t_core[num_tests]   = {sdiv[7:0], scnt[7:0]};
                    t_ramp[num_tests]   = {start, inc};
                    t_en[num_tests]     = en_v[0];
                    t_frames[num_tests] = frames;
                    limit += (frames + 4) * (sdiv + 1) * (scnt + 1) + 40;
                    total_frames += frames;
                    num_tests++;
                end
            end else if (tag == "F") begin
                n = $sscanf(line, "F %h", word);
                if (n == 1) begin
                    exp_q.push_back(word);
                end else begin
                    ok = 1'b0;
                end
            end
        end
        $fclose(fd);
        if (exp_q.size() != total_frames) begin
            ok = 1'b0;                   // Frame lines must match the frame counts
        end
        budget = limit;
    endtask

    task automatic run_test(input int idx);
        int          err_before;
        int          sync_period;
        int          limit;
        int          waited;
        int          nbits;
        logic [31:0] expected;
        cur_name    = t_name[idx];
        err_before  = errors;
        sync_period = (t_core[idx].subcycle_div + 1) * (t_core[idx].sync_count + 1);
        nbits       = 8 * (int'(t_spi[idx].dff) + 1);
        spi_cfg     = t_spi[idx];
        core_cfg    = t_core[idx];
        ramp_cfg    = t_ramp[idx];
        ramp_load   = 1'b1;
        step_clock();
        ramp_load = 1'b0;
        repeat (4) step_clock();            // Driver latches the new idle levels
        check_value("idle sclk", spi_cfg.cpol, spi_sclk);
        check_value("idle cs", !spi_cfg.sspol, spi_cs_n);
        rx_q.delete();
        bits_q.delete();
        mon_on = 1'b1;
        en     = t_en[idx];
        limit  = t_en[idx] ? (t_frames[idx] + 2) * sync_period : 4 * sync_period;
        waited = 0;
        while (waited < limit && (t_frames[idx] == 0 || rx_q.size() < t_frames[idx])) begin
            step_clock();
            waited++;
        end
        en     = 1'b0;
        mon_on = 1'b0;
        if (rx_q.size() < t_frames[idx]) begin
            errors++;
            $display("Test %s: only %0d of %0d frames arrived before the limit",
                     cur_name, rx_q.size(), t_frames[idx]);
        end else if (t_frames[idx] == 0) begin
            check_value("frame count", 0, rx_q.size());
        end
        for (int n = 0; n < t_frames[idx]; n++) begin
            expected = exp_q.pop_front();
            if (n < rx_q.size()) begin
                check_value($sformatf("word %0d", n), expected, rx_q[n]);
                check_value($sformatf("bits of word %0d", n), nbits, bits_q[n]);
            end
        end
        if (errors == err_before) begin
            $display("Test %s: ok, %0d frames", cur_name, rx_q.size());
        end else begin
            failed_tests++;
            $display("Test %s: %0d errors", cur_name, errors - err_before);
        end
    endtask

    initial begin : main
        bit ok;
        rst_n     = 1'b0;
        en        = 1'b0;
        ramp_load = 1'b0;
        core_cfg  = '0;
        ramp_cfg  = '0;
        spi_cfg   = '0;
        mon_on    = 1'b0;
        errors    = 0;
        checks    = 0;
        failed_tests = 0;
        read_trace(ok);
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        if (ok) begin
            for (int i = 0; i < num_tests; i++) begin
                run_test(i);
            end
        end else begin
            errors++;
            $display("The trace file could not be opened or is malformed");
        end
        $display("Tests: %0d, failed: %0d, checks: %0d, errors: %0d",
                 num_tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin : watchdog
        wait (budget > 0);
        repeat (budget) @(posedge clk);
        $display("Timeout: the run did not finish within %0d clock cycles", budget);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- src/wfg_top.sv
//**************************************************************************
// Waveform generator top. Timebase, ramp source and SPI driver in a chain.
//**************************************************************************
`default_nettype none

module wfg_top import wfg_pkg::*; #(
    parameter int AXIS_DATA_WIDTH = 32
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      en_i,
    input  core_cfg_t core_cfg_i,
    input  ramp_cfg_t ramp_cfg_i,
    input  logic      ramp_load_i,
    input  spi_cfg_t  spi_cfg_i,
    output logic      spi_sclk_o,
    output logic      spi_cs_no,
    output logic      spi_sdo_o
);

    logic                       core_sync;
    logic                       core_subcycle;
    logic                       axis_tvalid;
    logic                       axis_tready;
    logic                       axis_tlast;
    logic [AXIS_DATA_WIDTH-1:0] axis_tdata;

    wfg_core core_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .en_i       (en_i),
        .cfg_i      (core_cfg_i),
        .subcycle_o (core_subcycle),
        .sync_o     (core_sync)
    );

    wfg_stim_ramp #(
        .AXIS_DATA_WIDTH (AXIS_DATA_WIDTH)
    ) stim_ramp_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .load_i        (ramp_load_i),
        .cfg_i         (ramp_cfg_i),
        .axis_tready_i (axis_tready),
        .axis_tvalid_o (axis_tvalid),
        .axis_tlast_o  (axis_tlast),
        .axis_tdata_o  (axis_tdata)
    );

    wfg_drive_spi #(
        .AXIS_DATA_WIDTH (AXIS_DATA_WIDTH)
    ) drive_spi_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .core_sync_i     (core_sync),
        .core_subcycle_i (core_subcycle),
        .axis_tready_o   (axis_tready),
        .axis_tvalid_i   (axis_tvalid),
        .axis_tlast_i    (axis_tlast),
        .axis_tdata_i    (axis_tdata),
        .ctrl_en_i       (en_i),
        .cfg_i           (spi_cfg_i),
        .spi_sclk_o      (spi_sclk_o),
        .spi_cs_no       (spi_cs_no),
        .spi_sdo_o       (spi_sdo_o)
    );

endmodule

`default_nettype wire

//--- src/wfg_drive_spi.sv
//**************************************************************************
// SPI transmitter. Takes one stream word per sync pulse and shifts it out.
//**************************************************************************
`default_nettype none

module wfg_drive_spi import wfg_pkg::*; #(
    parameter int AXIS_DATA_WIDTH = 32
) (
    input  logic                       clk,
    input  logic                       rst_n,

    input  logic                       core_sync_i,
    input  logic                       core_subcycle_i, // Not used by this driver

    output logic                       axis_tready_o,
    input  logic                       axis_tvalid_i,
    input  logic                       axis_tlast_i,    // Frames ignore tlast
    input  logic [AXIS_DATA_WIDTH-1:0] axis_tdata_i,

    input  logic                       ctrl_en_i,
    input  spi_cfg_t                   cfg_i,

    output logic                       spi_sclk_o,
    output logic                       spi_cs_no,
    output logic                       spi_sdo_o
);

    spi_state_t                 state;
    spi_state_t                 state_next;

    spi_cfg_t                   cfg_q;    // Held for the whole frame
    clk_div_t                   counter;  // Clocks left in the half period
    logic [4:0]                 bit_cnt;  // Bits left after the current one
    logic [4:0]                 msb_idx;
    logic [AXIS_DATA_WIDTH-1:0] shift_q;
    logic                       spi_clk;  // Internal SCLK, 1 means leading phase
    logic                       spi_cs;   // Internal select, 1 means active
    logic                       ready;
    logic                       half_done;

    assign msb_idx   = {cfg_q.dff, 3'b111};
    assign half_done = (counter == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                // Syncs during a frame fall through here unseen
                if (core_sync_i && axis_tvalid_i && ctrl_en_i) begin
                    state_next = ST_SEND_DATA;
                end
            end
            ST_SEND_DATA: begin
                if (half_done && (bit_cnt == '0) && spi_clk) begin
                    state_next = ST_LAST_BIT;
                end
            end
            ST_LAST_BIT: begin
                if (half_done) begin
                    state_next = ST_IDLE; // After one trailing half period
                end
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg_q      <= '0;
            counter    <= '0;
            bit_cnt    <= '0;
            shift_q    <= '0;
            spi_clk    <= 1'b0;
            spi_cs     <= 1'b0;
            ready      <= 1'b0;
            spi_sclk_o <= 1'b0;
            spi_cs_no  <= 1'b0;
            spi_sdo_o  <= 1'b0;
        end else begin
            // Polarities applied on the pins
            spi_sclk_o <= cfg_q.cpol ^ spi_clk;
            spi_cs_no  <= cfg_q.sspol ? spi_cs : !spi_cs;
            spi_sdo_o  <= cfg_q.lsbfirst ? shift_q[0] : shift_q[msb_idx];
            ready      <= 1'b0;

            case (state_next)
                ST_IDLE: begin
                    cfg_q   <= cfg_i; // Track config between frames
                    counter <= '0;
                    spi_clk <= 1'b0;
                    spi_cs  <= 1'b0;
                    shift_q <= '0;
                end
                ST_SEND_DATA: begin
                    spi_cs <= 1'b1;
                    if (state == ST_IDLE) begin
                        shift_q <= axis_tdata_i;
                        ready   <= 1'b1; // Accept the word one cycle after sync
                        counter <= cfg_q.div;
                        bit_cnt <= msb_idx;
                    end else if (half_done) begin
                        spi_clk <= !spi_clk;
                        counter <= cfg_q.div;
                        if (spi_clk) begin
                            // Trailing edge, next bit goes out
                            bit_cnt <= bit_cnt - 1'b1;
                            if (cfg_q.lsbfirst) begin
                                shift_q <= {1'b0, shift_q[AXIS_DATA_WIDTH-1:1]};
                            end else begin
                                shift_q <= {shift_q[AXIS_DATA_WIDTH-2:0], 1'b0};
                            end
                        end
                    end else begin
                        counter <= counter - 1'b1;
                    end
                end
                ST_LAST_BIT: begin
                    spi_cs  <= 1'b1; // Select stays active for the tail
                    spi_clk <= 1'b0;
                    shift_q <= '0;
                    if (state == ST_SEND_DATA) begin
                        counter <= cfg_q.div;
                    end else begin
                        counter <= counter - 1'b1;
                    end
                end
                default: begin
                    spi_clk <= 1'b0;
                    spi_cs  <= 1'b0;
                end
            endcase
        end
    end

    assign axis_tready_o = ready;

endmodule

`default_nettype wire

//--- src/wfg_stim_ramp.sv
//**************************************************************************
// Ramp source on a valid/ready stream. Load sets the start, each beat adds inc.
//**************************************************************************
`default_nettype none

module wfg_stim_ramp import wfg_pkg::*; #(
    parameter int AXIS_DATA_WIDTH = 32
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       load_i,
    input  ramp_cfg_t                  cfg_i,
    input  logic                       axis_tready_i,
    output logic                       axis_tvalid_o,
    output logic                       axis_tlast_o,
    output logic [AXIS_DATA_WIDTH-1:0] axis_tdata_o
);

    logic [31:0] acc;     // Current sample
    logic [32:0] sum;     // Next sample with carry
    logic        carry_q; // Set when the last step wrapped
    logic        valid;

    assign valid = !load_i;
    assign sum   = {1'b0, acc} + {1'b0, cfg_i.inc};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc     <= '0;
            carry_q <= 1'b0;
        end else if (load_i) begin
            acc     <= cfg_i.start;
            carry_q <= 1'b0;
        end else if (axis_tready_i) begin
            // Advance only on an accepted beat, hold otherwise
            acc     <= sum[31:0];
            carry_q <= sum[32];
        end
    end

    assign axis_tvalid_o = valid;
    assign axis_tdata_o  = acc[AXIS_DATA_WIDTH-1:0]; // Lower bits only for narrow streams
    assign axis_tlast_o  = carry_q;

endmodule

`default_nettype wire

//--- src/wfg_core.sv
//**************************************************************************
// Timebase. Emits a subcycle pulse and a slower sync pulse while enabled.
//**************************************************************************
`default_nettype none

module wfg_core import wfg_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      en_i,
    input  core_cfg_t cfg_i,
    output logic      subcycle_o,
    output logic      sync_o
);

    pulse_div_t sub_cnt;  // Clocks left in this subcycle
    pulse_div_t sync_cnt; // Subcycles left until sync
    logic       sub_tick;

    assign sub_tick = (sub_cnt == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sub_cnt    <= '0;
            sync_cnt   <= '0;
            subcycle_o <= 1'b0;
            sync_o     <= 1'b0;
        end else if (!en_i) begin
            sub_cnt    <= '0; // First pulses come right after enable
            sync_cnt   <= '0;
            subcycle_o <= 1'b0;
            sync_o     <= 1'b0;
        end else begin
            subcycle_o <= sub_tick;
            sync_o     <= sub_tick && (sync_cnt == '0);
            if (sub_tick) begin
                sub_cnt <= cfg_i.subcycle_div;
                if (sync_cnt == '0) begin
                    sync_cnt <= cfg_i.sync_count;
                end else begin
                    sync_cnt <= sync_cnt - 1'b1;
                end
            end else begin
                sub_cnt <= sub_cnt - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/wfg_pkg.sv
//**************************************************************************
// Shared types of the waveform generator. RTL and testbench import this.
//**************************************************************************
`default_nettype none

package wfg_pkg;

    // Clock cycles per SCLK half period, minus one
    typedef logic [7:0] clk_div_t;

    // Frame size in bytes, minus one
    typedef logic [1:0] dff_t;

    // Divider for the core timebase
    typedef logic [7:0] pulse_div_t;

    typedef struct packed {
        clk_div_t div;
        logic     cpol;     // SCLK idle level
        logic     lsbfirst;
        dff_t     dff;
        logic     sspol;    // Chip select active level
    } spi_cfg_t;

    typedef struct packed {
        pulse_div_t subcycle_div; // Clocks per subcycle, minus one
        pulse_div_t sync_count;   // Subcycles per sync, minus one
    } core_cfg_t;

    typedef struct packed {
        logic [31:0] start;
        logic [31:0] inc;
    } ramp_cfg_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SEND_DATA,
        ST_LAST_BIT
    } spi_state_t;

endpackage

`default_nettype wire
